// File: hdl/mmu_pkg.sv
package mmu_pkg;

    // ============================================================
    // Vector types with a meaning
    // ============================================================

    // 32-bit virtual, 34-bit physical in Sv32
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [21:0] ppn_t;
    typedef logic [19:0] vpn_t;
    typedef logic [8:0]  asid_t;
    typedef logic [1:0]  priv_t;
    typedef logic [1:0]  access_t;
    typedef logic [3:0]  cause_t;
    // Low byte of a PTE
    typedef logic [7:0]  pte_flags_t;

    // ============================================================
    // Encodings
    // ============================================================

    // Same values as mstatus.MPP
    localparam priv_t PRIV_U = 2'b00;
    localparam priv_t PRIV_S = 2'b01;
    localparam priv_t PRIV_M = 2'b11;

    localparam access_t ACCESS_FETCH = 2'b00;
    localparam access_t ACCESS_LOAD  = 2'b01;
    localparam access_t ACCESS_STORE = 2'b10;

    // Page fault causes from mcause
    localparam cause_t CAUSE_FETCH_PF = 4'd12;
    localparam cause_t CAUSE_LOAD_PF  = 4'd13;
    localparam cause_t CAUSE_STORE_PF = 4'd15;

    // Bit positions inside pte_flags_t
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_G = 5;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    localparam int TLB_ENTRIES   = 16;
    localparam int PAGE_OFFSET_W = 12;

    // ============================================================
    // Bundles
    // ============================================================

    typedef struct packed {
        logic   req;
        vaddr_t vaddr;
        // Store when set, ignored on fetch
        logic   write;
    } xlate_req_t;

    typedef struct packed {
        logic   ready;
        logic   fault;
        paddr_t paddr;
    } xlate_rsp_t;

    typedef struct packed {
        logic       valid;
        vaddr_t     vaddr;
        asid_t      asid;
        ppn_t       ppn;
        pte_flags_t flags;
        logic       superpage;
    } tlb_refill_t;

    typedef struct packed {
        logic   valid;
        logic   asid_valid;
        asid_t  asid;
        logic   vaddr_valid;
        vaddr_t vaddr;
    } sfence_t;

endpackage

// File: hdl/sv32_tlb.sv
module sv32_tlb (
    input  logic                 clk,
    input  logic                 rst,
    input  mmu_pkg::vaddr_t      data_lookup,
    input  mmu_pkg::vaddr_t      fetch_lookup,
    input  mmu_pkg::asid_t       lookup_asid,
    output logic                 data_hit,
    output logic                 fetch_hit,
    output mmu_pkg::paddr_t      data_paddr,
    output mmu_pkg::paddr_t      fetch_paddr,
    output mmu_pkg::pte_flags_t  data_flags,
    output mmu_pkg::pte_flags_t  fetch_flags,
    input  mmu_pkg::tlb_refill_t refill,
    input  mmu_pkg::sfence_t     sfence
);
    import mmu_pkg::*;

    // Entry storage, valid bits separate
    logic [TLB_ENTRIES-1:0]         ent_valid;
    vpn_t                           ent_vpn   [TLB_ENTRIES];
    asid_t                          ent_asid  [TLB_ENTRIES];
    ppn_t                           ent_ppn   [TLB_ENTRIES];
    pte_flags_t                     ent_flags [TLB_ENTRIES];
    logic                           ent_super [TLB_ENTRIES];
    logic [$clog2(TLB_ENTRIES)-1:0] victim;
    logic [TLB_ENTRIES-1:0]         data_match;
    logic [TLB_ENTRIES-1:0]         fetch_match;
    logic [TLB_ENTRIES-1:0]         kill;

    // VPN compare, VPN[0] ignored for 4 MiB pages
    function automatic logic vpn_hit(int idx, vaddr_t va);
        return (ent_vpn[idx][19:10] == va[31:22]) &&
               (ent_super[idx] || ent_vpn[idx][9:0] == va[21:12]);
    endfunction

    // Global entries match any ASID
    function automatic logic entry_hit(int idx, vaddr_t va);
        return ent_valid[idx] &&
               (ent_flags[idx][PTE_G] || ent_asid[idx] == lookup_asid) &&
               vpn_hit(idx, va);
    endfunction

    // Superpage keeps 22 offset bits
    function automatic paddr_t make_paddr(int idx, vaddr_t va);
        if (ent_super[idx])
            return {ent_ppn[idx][21:10], va[21:0]};
        return {ent_ppn[idx], va[PAGE_OFFSET_W-1:0]};
    endfunction

    // ============================================================
    // Lookup, two independent ports
    // ============================================================
    always_comb begin
        data_hit    = 1'b0;
        data_paddr  = '0;
        data_flags  = '0;
        fetch_hit   = 1'b0;
        fetch_paddr = '0;
        fetch_flags = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            data_match[i]  = entry_hit(i, data_lookup);
            fetch_match[i] = entry_hit(i, fetch_lookup);
            if (data_match[i]) begin
                data_hit   = 1'b1;
                data_paddr = make_paddr(i, data_lookup);
                data_flags = ent_flags[i];
            end
            if (fetch_match[i]) begin
                fetch_hit   = 1'b1;
                fetch_paddr = make_paddr(i, fetch_lookup);
                fetch_flags = ent_flags[i];
            end
        end
    end

    // ============================================================
    // SFENCE.VMA selection
    // ============================================================
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            // ASID flush spares global entries
            kill[i] = sfence.valid &&
                      (!sfence.asid_valid ||
                       (ent_asid[i] == sfence.asid && !ent_flags[i][PTE_G])) &&
                      (!sfence.vaddr_valid || vpn_hit(i, sfence.vaddr));
        end
    end

    // Valid bits and round-robin victim
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            victim    <= '0;
        end else begin
            ent_valid <= ent_valid & ~kill;
            if (refill.valid) begin
                ent_valid[victim] <= 1'b1;
                victim            <= victim + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (refill.valid) begin
            ent_vpn[victim]   <= refill.vaddr[31:PAGE_OFFSET_W];
            ent_asid[victim]  <= refill.asid;
            ent_ppn[victim]   <= refill.ppn;
            ent_flags[victim] <= refill.flags;
            ent_super[victim] <= refill.superpage;
        end
    end

    // Refill only follows a miss, so no duplicates
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(data_match) && $onehot0(fetch_match));

endmodule

// File: hdl/pte_perm_check.sv
module pte_perm_check (
    input  mmu_pkg::pte_flags_t flags,
    input  mmu_pkg::priv_t      priv,
    input  mmu_pkg::access_t    access,
    input  logic                sum,
    input  logic                mxr,
    output logic                perm_ok
);
    import mmu_pkg::*;

    logic priv_ok;
    logic access_ok;

    // Privilege against the U bit
    always_comb begin
        case (priv)
            PRIV_U:  priv_ok = flags[PTE_U];
            // S needs SUM to touch user pages
            PRIV_S:  priv_ok = !flags[PTE_U] || sum;
            PRIV_M:  priv_ok = 1'b1;
            default: priv_ok = 1'b0;
        endcase
    end

    // Access type against R/W/X
    always_comb begin
        case (access)
            ACCESS_FETCH: access_ok = flags[PTE_X];
            // MXR makes executable pages readable
            ACCESS_LOAD:  access_ok = flags[PTE_R] || (mxr && flags[PTE_X]);
            // No hardware D update, clean page faults
            ACCESS_STORE: access_ok = flags[PTE_W] && flags[PTE_D];
            default:      access_ok = 1'b0;
        endcase
    end

    // Clear A faults as well
    assign perm_ok = flags[PTE_V] && flags[PTE_A] && priv_ok && access_ok;

endmodule

// File: hdl/page_table_walker.sv
module page_table_walker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 walk_start,
    input  mmu_pkg::vaddr_t      walk_vaddr,
    input  mmu_pkg::asid_t       walk_asid,
    input  mmu_pkg::ppn_t        root_ppn,
    output logic                 walk_done,
    output logic                 walk_fault,
    output mmu_pkg::tlb_refill_t refill,
    output logic                 mem_req,
    output mmu_pkg::paddr_t      mem_addr,
    input  logic [31:0]          mem_rdata,
    input  logic                 mem_ready
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        L1_READ,
        L0_READ,
        DONE
    } walk_state_t;

    walk_state_t state;
    vaddr_t      va_q;
    asid_t       asid_q;
    logic [31:0] pte_q;
    logic        super_q;
    logic        fault_q;
    logic        pte_bad;
    logic        pte_leaf;
    logic        ppn0_set;

    // Decode of the PTE on the bus
    // V clear, or W without R, is reserved
    assign pte_bad  = !mem_rdata[PTE_V] || (mem_rdata[PTE_W] && !mem_rdata[PTE_R]);
    assign pte_leaf = mem_rdata[PTE_R] || mem_rdata[PTE_X];
    // Misaligned superpage
    assign ppn0_set = |mem_rdata[19:10];

    // ============================================================
    // Walk sequencing
    // ============================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (walk_start) state <= L1_READ;
                // Leaf or bad PTE ends the walk at level 1
                L1_READ: if (mem_ready) state <= (pte_bad || pte_leaf) ? DONE : L0_READ;
                L0_READ: if (mem_ready) state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    // Walk payload and PTE address
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (walk_start) begin
                    va_q     <= walk_vaddr;
                    asid_q   <= walk_asid;
                    // root*4096 + VPN[1]*4
                    mem_addr <= {root_ppn, walk_vaddr[31:22], 2'b00};
                end
            end
            L1_READ: begin
                if (mem_ready) begin
                    pte_q    <= mem_rdata;
                    super_q  <= pte_leaf;
                    fault_q  <= pte_bad || (pte_leaf && ppn0_set);
                    // Next table, VPN[0]*4
                    mem_addr <= {mem_rdata[31:10], va_q[21:12], 2'b00};
                end
            end
            L0_READ: begin
                if (mem_ready) begin
                    pte_q   <= mem_rdata;
                    super_q <= 1'b0;
                    // Pointer at the last level
                    fault_q <= pte_bad || !pte_leaf;
                end
            end
            default: ;
        endcase
    end

    assign mem_req    = (state == L1_READ) || (state == L0_READ);
    assign walk_done  = (state == DONE);
    assign walk_fault = walk_done && fault_q;

    // Refill straight to the TLB
    assign refill.valid     = walk_done && !fault_q;
    assign refill.vaddr     = va_q;
    assign refill.asid      = asid_q;
    assign refill.ppn       = pte_q[31:10];
    assign refill.flags     = pte_q[7:0];
    assign refill.superpage = super_q;

    // Control only starts an idle walker
    assert property (@(posedge clk) disable iff (rst) walk_start |-> state == IDLE);
    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ready |=> $stable(mem_addr));

endmodule

// File: hdl/xlate_control.sv
module xlate_control (
    input  logic                clk,
    input  logic                rst,
    input  mmu_pkg::xlate_req_t ifetch,
    input  mmu_pkg::xlate_req_t data,
    input  logic [31:0]         satp,
    input  mmu_pkg::priv_t      priv_mode,
    input  mmu_pkg::priv_t      data_priv_mode,
    input  logic                fetch_hit,
    input  logic                data_hit,
    input  mmu_pkg::paddr_t     fetch_paddr,
    input  mmu_pkg::paddr_t     data_paddr,
    input  logic                fetch_perm_ok,
    input  logic                data_perm_ok,
    input  logic                walk_done,
    input  logic                walk_fault,
    output logic                walk_start,
    output mmu_pkg::vaddr_t     walk_vaddr,
    output mmu_pkg::asid_t      walk_asid,
    output mmu_pkg::ppn_t       root_ppn,
    output mmu_pkg::asid_t      lookup_asid,
    output mmu_pkg::access_t    data_access,
    output mmu_pkg::xlate_rsp_t ifetch_rsp,
    output mmu_pkg::xlate_rsp_t data_rsp,
    output mmu_pkg::cause_t     fault_cause,
    output mmu_pkg::vaddr_t     fault_vaddr
);
    import mmu_pkg::*;

    logic    fetch_vm;
    logic    data_vm;
    logic    fetch_miss;
    logic    data_miss;
    logic    busy;
    logic    owner_data;
    access_t owner_access;
    logic    fetch_walk_fault;
    logic    data_walk_fault;

    // One path's response
    function automatic xlate_rsp_t form_rsp(xlate_req_t r, logic vm, logic hit,
                                            logic ok, logic wf, paddr_t tlb_pa);
        xlate_rsp_t rsp;
        rsp.ready = r.req && (!vm || (hit && ok));
        rsp.fault = r.req && vm && ((hit && !ok) || wf);
        rsp.paddr = vm ? tlb_pa : {2'b00, r.vaddr};
        return rsp;
    endfunction

    function automatic cause_t cause_of(access_t acc);
        case (acc)
            ACCESS_STORE: return CAUSE_STORE_PF;
            ACCESS_LOAD:  return CAUSE_LOAD_PF;
            default:      return CAUSE_FETCH_PF;
        endcase
    endfunction

    // ============================================================
    // satp decode and bypass
    // ============================================================
    assign lookup_asid = satp[30:22];
    assign walk_asid   = satp[30:22];
    assign root_ppn    = satp[21:0];
    // M mode never translates
    assign fetch_vm    = satp[31] && (priv_mode != PRIV_M);
    assign data_vm     = satp[31] && (data_priv_mode != PRIV_M);
    assign data_access = data.write ? ACCESS_STORE : ACCESS_LOAD;

    // Walk arbitration, data first
    assign fetch_miss = ifetch.req && fetch_vm && !fetch_hit;
    assign data_miss  = data.req && data_vm && !data_hit;
    assign walk_start = !busy && (data_miss || fetch_miss);
    assign walk_vaddr = data_miss ? data.vaddr : ifetch.vaddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            owner_data   <= 1'b0;
            owner_access <= ACCESS_FETCH;
        end else if (walk_start) begin
            busy         <= 1'b1;
            owner_data   <= data_miss;
            owner_access <= data_miss ? data_access : ACCESS_FETCH;
        end else if (walk_done) begin
            busy <= 1'b0;
        end
    end

    // Walk fault pulses on the owner only
    assign data_walk_fault  = walk_done && walk_fault && owner_data;
    assign fetch_walk_fault = walk_done && walk_fault && !owner_data;

    // ============================================================
    // Responses and fault report
    // ============================================================
    assign ifetch_rsp = form_rsp(ifetch, fetch_vm, fetch_hit, fetch_perm_ok,
                                 fetch_walk_fault, fetch_paddr);
    assign data_rsp   = form_rsp(data, data_vm, data_hit, data_perm_ok,
                                 data_walk_fault, data_paddr);

    always_comb begin
        fault_cause = '0;
        fault_vaddr = '0;
        if (data_rsp.fault) begin
            fault_cause = cause_of(data_walk_fault ? owner_access : data_access);
            fault_vaddr = data.vaddr;
        end else if (ifetch_rsp.fault) begin
            fault_cause = cause_of(ACCESS_FETCH);
            fault_vaddr = ifetch.vaddr;
        end
    end

    // Walk faults land only on a path that still misses
    assert property (@(posedge clk) disable iff (rst)
        !(ifetch_rsp.ready && ifetch_rsp.fault) && !(data_rsp.ready && data_rsp.fault));

endmodule

// File: hdl/mmu_top.sv
module mmu_top (
    input  logic                clk,
    input  logic                rst,
    input  mmu_pkg::xlate_req_t ifetch,
    input  mmu_pkg::xlate_req_t data,
    input  logic [31:0]         satp,
    input  mmu_pkg::priv_t      priv_mode,
    input  mmu_pkg::priv_t      data_priv_mode,
    input  logic                mstatus_sum,
    input  logic                mstatus_mxr,
    input  mmu_pkg::sfence_t    sfence,
    output mmu_pkg::xlate_rsp_t ifetch_rsp,
    output mmu_pkg::xlate_rsp_t data_rsp,
    output mmu_pkg::cause_t     fault_cause,
    output mmu_pkg::vaddr_t     fault_vaddr,
    output logic                ptw_mem_req,
    output mmu_pkg::paddr_t     ptw_mem_addr,
    input  logic [31:0]         ptw_mem_rdata,
    input  logic                ptw_mem_ready
);
    import mmu_pkg::*;

    // TLB lookup results
    logic        fetch_hit;
    logic        data_hit;
    paddr_t      fetch_paddr;
    paddr_t      data_paddr;
    pte_flags_t  fetch_flags;
    pte_flags_t  data_flags;
    logic        fetch_perm_ok;
    logic        data_perm_ok;
    // Control to walker
    logic        walk_start;
    logic        walk_done;
    logic        walk_fault;
    vaddr_t      walk_vaddr;
    asid_t       walk_asid;
    asid_t       lookup_asid;
    ppn_t        root_ppn;
    access_t     data_access;
    tlb_refill_t refill;

    sv32_tlb tlb (
        .clk(clk), .rst(rst),
        .data_lookup(data.vaddr), .fetch_lookup(ifetch.vaddr),
        .lookup_asid(lookup_asid),
        .data_hit(data_hit), .fetch_hit(fetch_hit),
        .data_paddr(data_paddr), .fetch_paddr(fetch_paddr),
        .data_flags(data_flags), .fetch_flags(fetch_flags),
        .refill(refill), .sfence(sfence)
    );

    // Fetch path always checks for X
    pte_perm_check fetch_check (
        .flags(fetch_flags), .priv(priv_mode), .access(ACCESS_FETCH),
        .sum(mstatus_sum), .mxr(mstatus_mxr), .perm_ok(fetch_perm_ok)
    );

    // MPRV-aware privilege on data
    pte_perm_check data_check (
        .flags(data_flags), .priv(data_priv_mode), .access(data_access),
        .sum(mstatus_sum), .mxr(mstatus_mxr), .perm_ok(data_perm_ok)
    );

    page_table_walker ptw (
        .clk(clk), .rst(rst),
        .walk_start(walk_start), .walk_vaddr(walk_vaddr),
        .walk_asid(walk_asid), .root_ppn(root_ppn),
        .walk_done(walk_done), .walk_fault(walk_fault), .refill(refill),
        .mem_req(ptw_mem_req), .mem_addr(ptw_mem_addr),
        .mem_rdata(ptw_mem_rdata), .mem_ready(ptw_mem_ready)
    );

    xlate_control ctrl (
        .clk(clk), .rst(rst),
        .ifetch(ifetch), .data(data), .satp(satp),
        .priv_mode(priv_mode), .data_priv_mode(data_priv_mode),
        .fetch_hit(fetch_hit), .data_hit(data_hit),
        .fetch_paddr(fetch_paddr), .data_paddr(data_paddr),
        .fetch_perm_ok(fetch_perm_ok), .data_perm_ok(data_perm_ok),
        .walk_done(walk_done), .walk_fault(walk_fault),
        .walk_start(walk_start), .walk_vaddr(walk_vaddr),
        .walk_asid(walk_asid), .root_ppn(root_ppn),
        .lookup_asid(lookup_asid), .data_access(data_access),
        .ifetch_rsp(ifetch_rsp), .data_rsp(data_rsp),
        .fault_cause(fault_cause), .fault_vaddr(fault_vaddr)
    );

endmodule

// File: tests/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);

    // Free-running clock, 8 time units per period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over the first five rising edges
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tests/pt_memory.sv
module pt_memory (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  mmu_pkg::paddr_t addr,
    input  logic [1:0]      delay,
    output logic [31:0]     rdata,
    output logic            ready
);
    import mmu_pkg::*;

    logic [1:0]  wait_cnt;
    ppn_t        page;
    ppn_t        table_idx;
    logic [9:0]  idx;
    logic [11:0] super_ppn;
    vpn_t        vpn;

    // ============================================================
    // PTE contents, a pure function of the address
    // ============================================================
    always_comb begin
        page      = addr[33:12];
        idx       = addr[11:2];
        table_idx = page - 22'h100;
        super_ppn = 12'h200 + {2'b00, idx};
        vpn       = {table_idx[9:0], idx};
        rdata     = '0;
        if (page == 22'd1) begin
            // Root table at PPN 1
            if (idx > 10'd1000)
                // Superpage leaf, PPN[0] zero, G clear
                rdata = {super_ppn, 10'd0, 2'b00, 8'hdf};
            else
                // Pointer, only V set
                rdata = {22'h100 + {12'd0, idx}, 2'b00, 8'h01};
        end else if (page >= 22'h100 && page < 22'h500) begin
            // Leaf flags D A G U X W R V, U/W/V from VPN bits
            rdata = {2'b00, vpn ^ 20'h5a5a5, 2'b00,
                     3'b111, vpn[1], 1'b1, vpn[2], 1'b1, vpn[0]};
        end
    end

    // One-cycle ready pulse after the programmed wait
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready    <= 1'b0;
            wait_cnt <= '0;
        end else if (ready) begin
            ready <= 1'b0;
        end else if (req) begin
            if (wait_cnt >= delay) begin
                ready    <= 1'b1;
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

// File: tests/mmu_tb.sv
module mmu_tb;
    import mmu_pkg::*;

    logic        clk;
    logic        rst;
    xlate_req_t  ifetch;
    xlate_req_t  data;
    logic [31:0] satp;
    priv_t       priv_mode;
    priv_t       data_priv_mode;
    logic        mstatus_sum;
    logic        mstatus_mxr;
    sfence_t     sfence;
    xlate_rsp_t  ifetch_rsp;
    xlate_rsp_t  data_rsp;
    cause_t      fault_cause;
    vaddr_t      fault_vaddr;
    logic        ptw_mem_req;
    paddr_t      ptw_mem_addr;
    logic [31:0] ptw_mem_rdata;
    logic        ptw_mem_ready;
    logic [1:0]  mem_delay;
    // Run bookkeeping
    logic [31:0] rng;
    int          issued = 0;
    int          resp_cycles;
    logic        saw_walk;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    pt_memory page_mem (
        .clk(clk), .rst(rst), .req(ptw_mem_req), .addr(ptw_mem_addr),
        .delay(mem_delay), .rdata(ptw_mem_rdata), .ready(ptw_mem_ready)
    );

    mmu_top dut0 (.*);

    // ============================================================
    // Helpers and reference rules
    // ============================================================
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic expect_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
    endtask

    // xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 4 KiB page below index 512 with chosen low VPN bits
    function automatic vaddr_t page_addr(input logic [31:0] r, input logic [2:0] low);
        return {1'b0, r[30:15], low, r[11:0]};
    endfunction

    // Level-1 index 1001..1016
    function automatic vaddr_t super_addr(input logic [31:0] r);
        logic [9:0] idx;
        idx = 10'd1001 + {6'd0, r[25:22]};
        return {idx, r[21:0]};
    endfunction

    function automatic xlate_req_t make_req(input vaddr_t va, input logic write);
        xlate_req_t r;
        r.req   = 1'b1;
        r.vaddr = va;
        r.write = write;
        return r;
    endfunction

    // Flush all or only one address when addr_valid
    function automatic sfence_t make_sfence(input logic addr_valid, input vaddr_t va);
        sfence_t s;
        s.valid       = 1'b1;
        s.asid_valid  = 1'b0;
        s.asid        = '0;
        s.vaddr_valid = addr_valid;
        s.vaddr       = va;
        return s;
    endfunction

    // Leaf flags from the page-table rule
    function automatic pte_flags_t expect_flags(input vaddr_t va);
        if (va[31:22] > 10'd1000)
            return 8'hdf;
        return {3'b111, va[13], 1'b1, va[14], 1'b1, va[12]};
    endfunction

    function automatic paddr_t expect_paddr(input vaddr_t va);
        logic [11:0] ppn1;
        ppn1 = 12'h200 + {2'b00, va[31:22]};
        if (va[31:22] > 10'd1000)
            return {ppn1, va[21:0]};
        return {2'b00, va[31:12] ^ 20'h5a5a5, va[11:0]};
    endfunction

    function automatic logic expect_fault(input vaddr_t va, input priv_t p,
                                          input access_t acc);
        pte_flags_t f;
        logic       ok;
        f  = expect_flags(va);
        ok = f[PTE_V] && f[PTE_A];
        // User pages only from U or from S with SUM
        if (p == PRIV_U && !f[PTE_U])
            ok = 1'b0;
        if (p == PRIV_S && f[PTE_U] && !mstatus_sum)
            ok = 1'b0;
        if (acc == ACCESS_FETCH)
            ok = ok && f[PTE_X];
        else if (acc == ACCESS_LOAD)
            ok = ok && (f[PTE_R] || (mstatus_mxr && f[PTE_X]));
        else
            ok = ok && f[PTE_W] && f[PTE_D];
        return !ok;
    endfunction

    function automatic cause_t expect_cause(input access_t acc);
        if (acc == ACCESS_STORE)
            return 4'd15;
        if (acc == ACCESS_LOAD)
            return 4'd13;
        return 4'd12;
    endfunction

    // One request held until ready or fault and then checked
    task automatic access(input logic on_data, input vaddr_t va, input logic write);
        xlate_rsp_t rsp;
        access_t    acc;
        priv_t      p;
        logic       bypass;
        logic       exp_f;
        string      path;
        path = on_data ? "data_rsp" : "ifetch_rsp";
        acc  = on_data ? (write ? ACCESS_STORE : ACCESS_LOAD) : ACCESS_FETCH;
        @(posedge clk);
        p      = on_data ? data_priv_mode : priv_mode;
        bypass = !satp[31] || p == PRIV_M;
        exp_f  = !bypass && expect_fault(va, p, acc);
        if (on_data)
            data <= make_req(va, write);
        else
            ifetch <= make_req(va, 1'b0);
        rng = xorshift(rng);
        mem_delay <= rng[1:0];
        issued++;
        resp_cycles = 0;
        @(negedge clk);
        rsp = on_data ? data_rsp : ifetch_rsp;
        saw_walk = ptw_mem_req;
        while (!(rsp.ready || rsp.fault)) begin
            assert (resp_cycles < 40)
            else stop_on_error("No ready or fault for a held translation request");
            resp_cycles++;
            @(negedge clk);
            rsp = on_data ? data_rsp : ifetch_rsp;
            saw_walk = saw_walk || ptw_mem_req;
        end
        expect_value({path, ".fault"}, rsp.fault, exp_f);
        expect_value({path, ".ready"}, rsp.ready, !exp_f);
        if (exp_f) begin
            expect_value("fault_cause", fault_cause, expect_cause(acc));
            expect_value("fault_vaddr", fault_vaddr, va);
        end else begin
            expect_value({path, ".paddr"}, rsp.paddr,
                         bypass ? {2'b00, va} : expect_paddr(va));
        end
        @(posedge clk);
        if (on_data)
            data <= '0;
        else
            ifetch <= '0;
        // A walk started by the request shows on ptw_mem_req one cycle later
        @(negedge clk);
        saw_walk = saw_walk || ptw_mem_req;
        if (bypass)
            assert (resp_cycles == 0 && !saw_walk)
            else stop_on_error("Untranslated access was not answered in its request cycle");
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin : stimulus
        vaddr_t va;
        vaddr_t dva;
        vaddr_t fva;
        vaddr_t cached [$];
        logic   d_done;
        logic   f_done;
        rng            = 32'hd2f5;
        ifetch         = '0;
        data           = '0;
        satp           = '0;
        priv_mode      = PRIV_U;
        data_priv_mode = PRIV_U;
        mstatus_sum    = 1'b0;
        mstatus_mxr    = 1'b0;
        sfence         = '0;
        mem_delay      = '0;
        wait (rst === 1'b0);

        // Bare mode on every path and access type
        for (int n = 0; n < 4; n++) begin
            rng = xorshift(rng);
            access(n[0], rng, n[1]);
        end

        // Machine mode bypasses even with Sv32 on
        @(posedge clk);
        satp           <= {1'b1, 9'h005, 22'd1};
        priv_mode      <= PRIV_M;
        data_priv_mode <= PRIV_M;
        for (int n = 0; n < 4; n++) begin
            rng = xorshift(rng);
            access(n[1], rng, n[0]);
        end
        @(posedge clk);
        priv_mode      <= PRIV_U;
        data_priv_mode <= PRIV_U;

        // Mapped user loads whose repeat must hit without a walk
        for (int n = 0; n < 6; n++) begin
            rng = xorshift(rng);
            va = page_addr(rng, 3'b111);
            access(1'b1, va, 1'b0);
            cached.push_back(va);
            access(1'b1, va ^ 32'h0000_0abc, 1'b0);
            assert (resp_cycles == 0 && !saw_walk)
            else stop_on_error("Repeated access to a cached page did not hit");
        end

        // Superpage loads then a store and a fetch
        for (int n = 0; n < 4; n++) begin
            rng = xorshift(rng);
            access(n != 3, super_addr(rng), n == 2);
        end

        // Invalid leaf for each access type
        rng = xorshift(rng);
        access(1'b1, page_addr(rng, 3'b110), 1'b0);
        rng = xorshift(rng);
        access(1'b0, page_addr(rng, 3'b110), 1'b0);
        rng = xorshift(rng);
        access(1'b1, page_addr(rng, 3'b110), 1'b1);
        // Valid leaf but permission denied at hit time
        rng = xorshift(rng);
        access(1'b1, page_addr(rng, 3'b101), 1'b0);
        rng = xorshift(rng);
        access(1'b1, page_addr(rng, 3'b011), 1'b1);
        rng = xorshift(rng);
        access(1'b0, page_addr(rng, 3'b101), 1'b0);

        // S mode on a user page without SUM first
        rng = xorshift(rng);
        va = page_addr(rng, 3'b111);
        @(posedge clk);
        data_priv_mode <= PRIV_S;
        access(1'b1, va, 1'b0);
        @(posedge clk);
        mstatus_sum <= 1'b1;
        access(1'b1, va, 1'b0);
        @(posedge clk);
        data_priv_mode <= PRIV_U;
        mstatus_sum    <= 1'b0;

        // Address sfence drops one page only
        @(posedge clk);
        sfence <= make_sfence(1'b1, cached[0]);
        @(posedge clk);
        sfence <= '0;
        access(1'b1, cached[1], 1'b0);
        assert (resp_cycles == 0 && !saw_walk)
        else stop_on_error("A page not named by the sfence was lost from the TLB");
        access(1'b1, cached[0], 1'b0);
        assert (saw_walk)
        else stop_on_error("Access after an address sfence did not walk the page table");

        // Full flush then both paths miss together
        @(posedge clk);
        sfence <= make_sfence(1'b0, '0);
        @(posedge clk);
        sfence <= '0;
        rng = xorshift(rng);
        dva = page_addr(rng, 3'b111);
        rng = xorshift(rng);
        fva = page_addr(rng, 3'b111);
        fva[30] = ~dva[30];
        @(posedge clk);
        data   <= make_req(dva, 1'b0);
        ifetch <= make_req(fva, 1'b0);
        issued += 2;
        @(negedge clk);
        while (!ptw_mem_req)
            @(negedge clk);
        // Data wins the walker
        expect_value("ptw_mem_addr", ptw_mem_addr, {22'd1, dva[31:22], 2'b00});
        d_done = 1'b0;
        f_done = 1'b0;
        while (!(d_done && f_done)) begin
            @(negedge clk);
            if (!d_done && (data_rsp.ready || data_rsp.fault)) begin
                expect_value("data_rsp.fault", data_rsp.fault, 1'b0);
                expect_value("data_rsp.paddr", data_rsp.paddr, expect_paddr(dva));
                d_done = 1'b1;
            end
            if (!f_done && (ifetch_rsp.ready || ifetch_rsp.fault)) begin
                expect_value("ifetch_rsp.fault", ifetch_rsp.fault, 1'b0);
                expect_value("ifetch_rsp.paddr", ifetch_rsp.paddr, expect_paddr(fva));
                f_done = 1'b1;
            end
            @(posedge clk);
            if (d_done)
                data <= '0;
            if (f_done)
                ifetch <= '0;
        end

        $display("All tests passed");
        $finish;
    end

    // Limit grows with every issued request
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 40 * issued + 200)
                stop_on_error("Timeout, the run did not finish in time");
        end
    end

endmodule

// File: tb.f
hdl/mmu_pkg.sv
hdl/sv32_tlb.sv
hdl/pte_perm_check.sv
hdl/page_table_walker.sv
hdl/xlate_control.sv
hdl/mmu_top.sv
tests/tb_clock.sv
tests/pt_memory.sv
tests/mmu_tb.sv
